// ==== source/lc4_pkg.sv ====
package lc4_pkg;

  localparam int WORD_W    = 16;  // data, insn and pc words
  localparam int REG_SEL_W = 3;   // eight registers
  localparam int ALU_OP_W  = 3;

  localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;

  // major opcodes kept in this core
  localparam logic [3:0] OPC_ARITH = 4'b0001;
  localparam logic [3:0] OPC_LOGIC = 4'b0101;
  localparam logic [3:0] OPC_CONST = 4'b1001;

  // alu operation select
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 3'd0;
  localparam logic [ALU_OP_W-1:0] ALU_MUL  = 3'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 3'd2;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 3'd3;
  localparam logic [ALU_OP_W-1:0] ALU_NOT  = 3'd4;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 3'd5;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 3'd6;
  localparam logic [ALU_OP_W-1:0] ALU_PASS = 3'd7;  // b operand straight through, used by CONST

  // per-lane stall trace as seen at writeback
  localparam logic [1:0] STALL_NONE        = 2'd0;
  localparam logic [1:0] STALL_SUPERSCALAR = 2'd1;
  localparam logic [1:0] STALL_EMPTY       = 2'd2;  // bubble, nothing issued yet

  // one insn word seen three ways, picked by opcode and bit 5
  typedef union packed {
    struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;
      logic [REG_SEL_W-1:0] rs;
      logic [2:0]           subop;
      logic [REG_SEL_W-1:0] rt;
    } r;  // register form
    struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;
      logic [REG_SEL_W-1:0] rs;
      logic                 imm_flag;  // set for ADD/AND immediate
      logic [4:0]           imm5;
    } i;  // immediate form
    struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;
      logic [8:0]           imm9;
    } c;  // CONST form
  } lc4_insn_u;

endpackage

// ==== source/lc4_alu.sv ====
`timescale 1ns/1ps

module lc4_alu (
  input  logic [lc4_pkg::ALU_OP_W-1:0] i_op,
  input  logic [lc4_pkg::WORD_W-1:0]   i_a,
  input  logic [lc4_pkg::WORD_W-1:0]   i_b,
  output logic [lc4_pkg::WORD_W-1:0]   o_result
);

  logic [2*lc4_pkg::WORD_W-1:0] product;

  assign product = i_a * i_b;  // full width, only the low half is kept

  always_comb begin
    case (i_op)
      lc4_pkg::ALU_ADD: begin
        o_result = i_a + i_b;
      end
      lc4_pkg::ALU_MUL: begin
        o_result = product[lc4_pkg::WORD_W-1:0];
      end
      lc4_pkg::ALU_SUB: begin
        o_result = i_a - i_b;
      end
      lc4_pkg::ALU_AND: begin
        o_result = i_a & i_b;
      end
      lc4_pkg::ALU_NOT: begin
        o_result = ~i_a;  // b not looked at
      end
      lc4_pkg::ALU_OR: begin
        o_result = i_a | i_b;
      end
      lc4_pkg::ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      lc4_pkg::ALU_PASS: begin
        o_result = i_b;  // immediate for CONST
      end
      default: begin
        o_result = '0;
      end
    endcase
  end

endmodule

// ==== source/lc4_regfile_2w.sv ====
`timescale 1ns/1ps

module lc4_regfile_2w (
  input  logic                          gwe,
  input  logic                          i_rst,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs_a,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt_a,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs_b,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt_b,
  output logic [lc4_pkg::WORD_W-1:0]    o_rs_data_a,
  output logic [lc4_pkg::WORD_W-1:0]    o_rt_data_a,
  output logic [lc4_pkg::WORD_W-1:0]    o_rs_data_b,
  output logic [lc4_pkg::WORD_W-1:0]    o_rt_data_b,
  input  logic                          i_we_a,
  input  logic                          i_we_b,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rd_a,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rd_b,
  input  logic [lc4_pkg::WORD_W-1:0]    i_wdata_a,
  input  logic [lc4_pkg::WORD_W-1:0]    i_wdata_b
);

  logic [lc4_pkg::WORD_W-1:0] regs [2**lc4_pkg::REG_SEL_W];

  // write-through read, lane B is younger so it wins over A
  function automatic logic [lc4_pkg::WORD_W-1:0] read_port(
    input logic [lc4_pkg::REG_SEL_W-1:0] sel
  );
    if (i_we_b && (i_rd_b == sel)) return i_wdata_b;
    if (i_we_a && (i_rd_a == sel)) return i_wdata_a;
    return regs[sel];
  endfunction

  always_comb begin
    o_rs_data_a = read_port(i_rs_a);
    o_rt_data_a = read_port(i_rt_a);
    o_rs_data_b = read_port(i_rs_b);
    o_rt_data_b = read_port(i_rt_b);
  end

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int k = 0; k < 2**lc4_pkg::REG_SEL_W; k++) regs[k] <= '0;
    end else begin
      if (i_we_a) regs[i_rd_a] <= i_wdata_a;
      if (i_we_b) regs[i_rd_b] <= i_wdata_b;  // later assignment, B kept on a tie
    end
  end

endmodule

// ==== source/lc4_lane.sv ====
`timescale 1ns/1ps

module lc4_lane (
  input  logic                          gwe,
  input  logic                          i_rst,
  // decoded slot from issue
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rd,
  input  logic                          i_we,
  input  logic [lc4_pkg::ALU_OP_W-1:0]  i_op,
  input  logic [lc4_pkg::WORD_W-1:0]    i_imm,
  input  logic                          i_use_imm,
  // register file read side
  input  logic [lc4_pkg::WORD_W-1:0]    i_rs_data,
  input  logic [lc4_pkg::WORD_W-1:0]    i_rt_data,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rs,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rt,
  // writeback
  output logic                          o_wb_we,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_wb_rd,
  output logic [lc4_pkg::WORD_W-1:0]    o_wb_data,
  output logic [2:0]                    o_wb_nzp
);

  logic [lc4_pkg::REG_SEL_W-1:0] x_rs, x_rt, x_rd;
  logic                          x_we;
  logic [lc4_pkg::ALU_OP_W-1:0]  x_op;
  logic                          x_use_imm;
  logic [lc4_pkg::WORD_W-1:0]    x_imm;
  logic [lc4_pkg::WORD_W-1:0]    alu_b, alu_result;
  logic [2:0]                    nzp;

  // execute register
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      x_rs      <= '0;
      x_rt      <= '0;
      x_rd      <= '0;
      x_we      <= 1'b0;
      x_op      <= lc4_pkg::ALU_ADD;
      x_use_imm <= 1'b0;
    end else begin
      x_rs      <= i_rs;
      x_rt      <= i_rt;
      x_rd      <= i_rd;
      x_we      <= i_we;
      x_op      <= i_op;
      x_use_imm <= i_use_imm;
    end
  end

  always_ff @(posedge gwe) begin
    x_imm <= i_imm;  // b operand for immediate forms and CONST
  end

  assign o_rs  = x_rs;  // regfile answers in the same cycle
  assign o_rt  = x_rt;
  assign alu_b = x_use_imm ? x_imm : i_rt_data;

  lc4_alu alu0 (
    .i_op     (x_op),
    .i_a      (i_rs_data),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  always_comb begin
    if (alu_result[lc4_pkg::WORD_W-1]) nzp = 3'b100;
    else if (alu_result == '0)         nzp = 3'b010;
    else                               nzp = 3'b001;
  end

  // writeback register
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      o_wb_we   <= 1'b0;
      o_wb_rd   <= '0;
      o_wb_data <= '0;
      o_wb_nzp  <= 3'b000;
    end else begin
      o_wb_we   <= x_we;
      o_wb_rd   <= x_rd;
      o_wb_data <= alu_result;
      o_wb_nzp  <= nzp;
    end
  end

endmodule

// ==== source/lc4_issue_ctrl.sv ====
`timescale 1ns/1ps

module lc4_issue_ctrl (
  input  logic                          gwe,
  input  logic                          i_rst,
  input  logic [lc4_pkg::WORD_W-1:0]    i_insn_a,
  input  logic [lc4_pkg::WORD_W-1:0]    i_insn_b,
  output logic [lc4_pkg::WORD_W-1:0]    o_pc,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rs_a,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rt_a,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rs_b,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rt_b,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rd_a,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rd_b,
  output logic                          o_we_a,
  output logic                          o_we_b,
  output logic [lc4_pkg::ALU_OP_W-1:0]  o_op_a,
  output logic [lc4_pkg::ALU_OP_W-1:0]  o_op_b,
  output logic [lc4_pkg::WORD_W-1:0]    o_imm_a,
  output logic [lc4_pkg::WORD_W-1:0]    o_imm_b,
  output logic                          o_use_imm_a,
  output logic                          o_use_imm_b,
  output logic [1:0]                    o_stall_a,
  output logic [1:0]                    o_stall_b
);

  logic                          we_b_raw;  // before the pair check
  logic                          hold_b;
  logic [1:0]                    stall_x_a, stall_x_b;

  // one slot: op, selects, immediate and whether it writes
  function automatic void decode_slot(
    input  lc4_pkg::lc4_insn_u            insn,
    output logic [lc4_pkg::ALU_OP_W-1:0]  op,
    output logic [lc4_pkg::REG_SEL_W-1:0] rd, rs, rt,
    output logic [lc4_pkg::WORD_W-1:0]    imm,
    output logic                          use_imm, we
  );
    op      = lc4_pkg::ALU_ADD;
    rd      = insn.r.rd;
    rs      = insn.r.rs;
    rt      = insn.r.rt;
    imm     = {{(lc4_pkg::WORD_W-5){insn.i.imm5[4]}}, insn.i.imm5};
    use_imm = insn.i.imm_flag;
    we      = 1'b1;
    case (insn.r.opcode)
      lc4_pkg::OPC_ARITH: begin
        if (!insn.i.imm_flag) begin
          case (insn.r.subop)
            3'b000:  op = lc4_pkg::ALU_ADD;
            3'b001:  op = lc4_pkg::ALU_MUL;
            3'b010:  op = lc4_pkg::ALU_SUB;
            default: we = 1'b0;  // DIV not supported here
          endcase
        end
      end
      lc4_pkg::OPC_LOGIC: begin
        if (insn.i.imm_flag) op = lc4_pkg::ALU_AND;
        else begin
          case (insn.r.subop)
            3'b000:  op = lc4_pkg::ALU_AND;
            3'b001:  op = lc4_pkg::ALU_NOT;
            3'b010:  op = lc4_pkg::ALU_OR;
            default: op = lc4_pkg::ALU_XOR;
          endcase
        end
      end
      lc4_pkg::OPC_CONST: begin
        op      = lc4_pkg::ALU_PASS;
        imm     = {{(lc4_pkg::WORD_W-9){insn.c.imm9[8]}}, insn.c.imm9};
        use_imm = 1'b1;
      end
      default: begin
        use_imm = 1'b0;
        we      = 1'b0;  // NOP and everything else
      end
    endcase
  endfunction

  // does this insn read register idx as an operand
  function automatic logic reads_reg(
    input lc4_pkg::lc4_insn_u            insn,
    input logic [lc4_pkg::REG_SEL_W-1:0] idx
  );
    logic rs_hit, rt_hit;
    rs_hit = (insn.r.rs == idx);
    rt_hit = (insn.r.rt == idx);
    if (insn.r.opcode != lc4_pkg::OPC_ARITH && insn.r.opcode != lc4_pkg::OPC_LOGIC) return 1'b0;
    if (insn.i.imm_flag) return rs_hit;
    case (insn.r.subop)
      3'b000, 3'b010: return rs_hit || rt_hit;
      3'b001:  return (insn.r.opcode == lc4_pkg::OPC_LOGIC) ? rs_hit : (rs_hit || rt_hit);
      default: return (insn.r.opcode == lc4_pkg::OPC_LOGIC) && (rs_hit || rt_hit);  // XOR
    endcase
  endfunction

  always_comb begin
    decode_slot(i_insn_a, o_op_a, o_rd_a, o_rs_a, o_rt_a, o_imm_a, o_use_imm_a, o_we_a);
    decode_slot(i_insn_b, o_op_b, o_rd_b, o_rs_b, o_rt_b, o_imm_b, o_use_imm_b, we_b_raw);
  end

  // B needs A's result in the same pair, so B becomes a bubble and is refetched as next A
  assign hold_b = o_we_a && reads_reg(i_insn_b, o_rd_a);
  assign o_we_b = we_b_raw && !hold_b;

  always_ff @(posedge gwe) begin
    if (i_rst) o_pc <= lc4_pkg::RESET_PC;
    else       o_pc <= o_pc + {{(lc4_pkg::WORD_W-2){1'b0}}, hold_b ? 2'd1 : 2'd2};
  end

  // stall trace rides along with the lanes, x stage then writeback
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      stall_x_a <= lc4_pkg::STALL_EMPTY;
      stall_x_b <= lc4_pkg::STALL_EMPTY;
      o_stall_a <= lc4_pkg::STALL_EMPTY;
      o_stall_b <= lc4_pkg::STALL_EMPTY;
    end else begin
      stall_x_a <= lc4_pkg::STALL_NONE;  // A always issues
      stall_x_b <= hold_b ? lc4_pkg::STALL_SUPERSCALAR : lc4_pkg::STALL_NONE;
      o_stall_a <= stall_x_a;
      o_stall_b <= stall_x_b;
    end
  end

endmodule

// ==== source/lc4_superscalar.sv ====
`timescale 1ns/1ps

module lc4_superscalar (
  input  logic                          gwe,
  input  logic                          i_rst,
  output logic [lc4_pkg::WORD_W-1:0]    o_cur_pc,
  input  logic [lc4_pkg::WORD_W-1:0]    i_cur_insn_a,  // insn at o_cur_pc
  input  logic [lc4_pkg::WORD_W-1:0]    i_cur_insn_b,  // insn at o_cur_pc + 1
  output logic                          o_wb_we_a,
  output logic                          o_wb_we_b,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_wb_rd_a,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_wb_rd_b,
  output logic [lc4_pkg::WORD_W-1:0]    o_wb_data_a,
  output logic [lc4_pkg::WORD_W-1:0]    o_wb_data_b,
  output logic [2:0]                    o_wb_nzp_a,
  output logic [2:0]                    o_wb_nzp_b,
  output logic [1:0]                    o_stall_a,
  output logic [1:0]                    o_stall_b
);

  // issue to lanes
  logic [lc4_pkg::REG_SEL_W-1:0] d_rs_a, d_rt_a, d_rd_a, d_rs_b, d_rt_b, d_rd_b;
  logic                          d_we_a, d_we_b, d_use_imm_a, d_use_imm_b;
  logic [lc4_pkg::ALU_OP_W-1:0]  d_op_a, d_op_b;
  logic [lc4_pkg::WORD_W-1:0]    d_imm_a, d_imm_b;
  // lanes to regfile
  logic [lc4_pkg::REG_SEL_W-1:0] x_rs_a, x_rt_a, x_rs_b, x_rt_b;
  logic [lc4_pkg::WORD_W-1:0]    rs_data_a, rt_data_a, rs_data_b, rt_data_b;

  lc4_issue_ctrl issue0 (
    .gwe (gwe), .i_rst (i_rst),
    .i_insn_a (i_cur_insn_a), .i_insn_b (i_cur_insn_b), .o_pc (o_cur_pc),
    .o_rs_a (d_rs_a), .o_rt_a (d_rt_a), .o_rs_b (d_rs_b), .o_rt_b (d_rt_b),
    .o_rd_a (d_rd_a), .o_rd_b (d_rd_b), .o_we_a (d_we_a), .o_we_b (d_we_b),
    .o_op_a (d_op_a), .o_op_b (d_op_b), .o_imm_a (d_imm_a), .o_imm_b (d_imm_b),
    .o_use_imm_a (d_use_imm_a), .o_use_imm_b (d_use_imm_b),
    .o_stall_a (o_stall_a), .o_stall_b (o_stall_b)
  );

  lc4_lane lane_a (
    .gwe (gwe), .i_rst (i_rst),
    .i_rs (d_rs_a), .i_rt (d_rt_a), .i_rd (d_rd_a), .i_we (d_we_a),
    .i_op (d_op_a), .i_imm (d_imm_a), .i_use_imm (d_use_imm_a),
    .i_rs_data (rs_data_a), .i_rt_data (rt_data_a), .o_rs (x_rs_a), .o_rt (x_rt_a),
    .o_wb_we (o_wb_we_a), .o_wb_rd (o_wb_rd_a),
    .o_wb_data (o_wb_data_a), .o_wb_nzp (o_wb_nzp_a)
  );

  lc4_lane lane_b (
    .gwe (gwe), .i_rst (i_rst),
    .i_rs (d_rs_b), .i_rt (d_rt_b), .i_rd (d_rd_b), .i_we (d_we_b),
    .i_op (d_op_b), .i_imm (d_imm_b), .i_use_imm (d_use_imm_b),
    .i_rs_data (rs_data_b), .i_rt_data (rt_data_b), .o_rs (x_rs_b), .o_rt (x_rt_b),
    .o_wb_we (o_wb_we_b), .o_wb_rd (o_wb_rd_b),
    .o_wb_data (o_wb_data_b), .o_wb_nzp (o_wb_nzp_b)
  );

  // both writebacks land here and are read through by the execute stage
  lc4_regfile_2w regfile0 (
    .gwe (gwe), .i_rst (i_rst),
    .i_rs_a (x_rs_a), .i_rt_a (x_rt_a), .i_rs_b (x_rs_b), .i_rt_b (x_rt_b),
    .o_rs_data_a (rs_data_a), .o_rt_data_a (rt_data_a),
    .o_rs_data_b (rs_data_b), .o_rt_data_b (rt_data_b),
    .i_we_a (o_wb_we_a), .i_we_b (o_wb_we_b),
    .i_rd_a (o_wb_rd_a), .i_rd_b (o_wb_rd_b),
    .i_wdata_a (o_wb_data_a), .i_wdata_b (o_wb_data_b)
  );

endmodule

// ==== test/tb_lc4_superscalar.sv ====
`timescale 1ns/1ps

module tb_lc4_superscalar;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int DRAIN_CYCLES = 3;  // samples once the pc has passed the program
  localparam int MAX_TESTS    = 16;
  localparam int MAX_WORDS    = 256;

  logic                          gwe = 1'b0;
  logic                          i_rst;
  logic [lc4_pkg::WORD_W-1:0]    i_cur_insn_a, i_cur_insn_b, o_cur_pc;
  logic                          o_wb_we_a, o_wb_we_b;
  logic [lc4_pkg::REG_SEL_W-1:0] o_wb_rd_a, o_wb_rd_b;
  logic [lc4_pkg::WORD_W-1:0]    o_wb_data_a, o_wb_data_b;
  logic [2:0]                    o_wb_nzp_a, o_wb_nzp_b;
  logic [1:0]                    o_stall_a, o_stall_b;

  // one entry per program word and the writeback it must produce
  logic [15:0] prog_word [MAX_WORDS];
  logic [2:0]  exp_rd    [MAX_WORDS];
  logic [15:0] exp_data  [MAX_WORDS];
  logic [2:0]  exp_nzp   [MAX_WORDS];
  string       test_name  [MAX_TESTS];
  int          prog_start [MAX_TESTS];
  int          prog_len   [MAX_TESTS];
  int          exp_stalls [MAX_TESTS];

  int    n_tests, n_words, cur_test, err_count, test_errs, tests_failed, got_n, stall_n;
  bit    stim_loaded = 1'b0;
  string cur_name;

  lc4_superscalar dut0 (
    .gwe (gwe), .i_rst (i_rst), .o_cur_pc (o_cur_pc),
    .i_cur_insn_a (i_cur_insn_a), .i_cur_insn_b (i_cur_insn_b),
    .o_wb_we_a (o_wb_we_a), .o_wb_we_b (o_wb_we_b),
    .o_wb_rd_a (o_wb_rd_a), .o_wb_rd_b (o_wb_rd_b),
    .o_wb_data_a (o_wb_data_a), .o_wb_data_b (o_wb_data_b),
    .o_wb_nzp_a (o_wb_nzp_a), .o_wb_nzp_b (o_wb_nzp_b),
    .o_stall_a (o_stall_a), .o_stall_b (o_stall_b)
  );

  always #(CLK_PERIOD/2) gwe = ~gwe;

  // N for negative, Z for zero, P otherwise
  function automatic logic [2:0] sign_zero_code(input logic [15:0] value);
    if (value[15]) return 3'b100;
    if (value == 16'h0000) return 3'b010;
    return 3'b001;
  endfunction

  function automatic logic [15:0] fetch_word(input logic [15:0] addr);
    logic [15:0] off;
    off = addr - lc4_pkg::RESET_PC;
    if (off < prog_len[cur_test]) return prog_word[prog_start[cur_test] + off];
    return 16'h0000;  // NOP past the program
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: %s expected %0h, got %0h", cur_name, what, expected, actual);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic load_stim(output bit ok);
    int              fd, code, rd, stalls;
    string           tag, name;
    logic [15:0]     word, data;
    logic [2:0]      nzp;
    logic [31:0]     rnd;
    logic [8:0]      imm9;
    logic [8*256-1:0] line_buf;
    ok      = 1'b1;
    n_tests = 0;
    n_words = 0;
    fd = $fopen("test/lc4_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/lc4_stim.txt");
      ok = 1'b0;
      return;
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        code = $fgets(line_buf, fd);  // rest of a note line
      end else if (tag == "test") begin
        code = $fscanf(fd, "%s %d", name, stalls);
        test_name[n_tests]  = name;
        exp_stalls[n_tests] = stalls;
        prog_start[n_tests] = n_words;
        prog_len[n_tests]   = 0;
        n_tests++;
      end else if (tag == "p" || tag == "r") begin
        if (tag == "p") begin
          code = $fscanf(fd, "%h %d %h %b", word, rd, data, nzp);
        end else begin
          code = $fscanf(fd, "%d", rd);
          rnd  = $urandom;
          imm9 = rnd[8:0];
          word = {lc4_pkg::OPC_CONST, rd[2:0], imm9};
          data = {{7{imm9[8]}}, imm9};  // CONST sign-extends imm9
          nzp  = sign_zero_code(data);
        end
        prog_word[n_words] = word;
        exp_rd[n_words]    = rd[2:0];
        exp_data[n_words]  = data;
        exp_nzp[n_words]   = nzp;
        n_words++;
        prog_len[n_tests-1]++;
      end else begin
        $display("unknown token %s in the stimulus file", tag);
        ok = 1'b0;
      end
    end
    $fclose(fd);
  endtask

  task automatic take_writeback(input logic [2:0] rd, input logic [15:0] data,
                                input logic [2:0] nzp);
    int idx;
    idx = prog_start[cur_test] + got_n;
    if (got_n >= prog_len[cur_test]) begin
      $display("%s: extra writeback to r%0d after the expected list ran out", cur_name, rd);
      err_count++;
      test_errs++;
    end else begin
      check_value($sformatf("writeback %0d rd", got_n), exp_rd[idx], rd);
      check_value($sformatf("writeback %0d data", got_n), exp_data[idx], data);
      check_value($sformatf("writeback %0d nzp", got_n), exp_nzp[idx], nzp);
    end
    got_n++;
  endtask

  task automatic sample_outputs();
    if (o_wb_we_a) begin
      take_writeback(o_wb_rd_a, o_wb_data_a, o_wb_nzp_a);  // A is older
      check_value("stall a at writeback", lc4_pkg::STALL_NONE, o_stall_a);
    end
    if (o_wb_we_b) begin
      take_writeback(o_wb_rd_b, o_wb_data_b, o_wb_nzp_b);
      check_value("stall b at writeback", lc4_pkg::STALL_NONE, o_stall_b);
    end
    if (o_stall_a == lc4_pkg::STALL_SUPERSCALAR) stall_n++;
    if (o_stall_b == lc4_pkg::STALL_SUPERSCALAR) stall_n++;
  endtask

  task automatic drive_fetch();
    i_cur_insn_a = fetch_word(o_cur_pc);
    i_cur_insn_b = fetch_word(o_cur_pc + 16'd1);
  endtask

  task automatic run_test(input int t);
    int          drained;
    logic [15:0] off;
    cur_test  = t;
    cur_name  = test_name[t];
    test_errs = 0;
    got_n     = 0;
    stall_n   = 0;
    drained   = 0;
    @(negedge gwe);
    i_rst        = 1'b1;
    i_cur_insn_a = '0;
    i_cur_insn_b = '0;
    repeat (RESET_CYCLES) @(negedge gwe);
    i_rst = 1'b0;
    // state right out of reset before any writeback
    check_value("pc after reset", lc4_pkg::RESET_PC, o_cur_pc);
    check_value("stall a after reset", lc4_pkg::STALL_EMPTY, o_stall_a);
    check_value("stall b after reset", lc4_pkg::STALL_EMPTY, o_stall_b);
    check_value("wb enable a after reset", 1'b0, o_wb_we_a);
    check_value("wb enable b after reset", 1'b0, o_wb_we_b);
    drive_fetch();
    while (drained < DRAIN_CYCLES) begin
      @(negedge gwe);
      sample_outputs();
      off = o_cur_pc - lc4_pkg::RESET_PC;
      if (off >= prog_len[t]) drained++;
      drive_fetch();
    end
    check_value("writeback count", prog_len[t], got_n);
    check_value("superscalar stalls", exp_stalls[t], stall_n);
    if (test_errs == 0) begin
      $display("PASS %s", cur_name);
    end else begin
      $display("[FAIL] %s: %0d mismatches", cur_name, test_errs);
      tests_failed++;
    end
  endtask

  initial begin : main_seq
    bit ok;
    int seed;
    i_rst        = 1'b1;
    i_cur_insn_a = '0;
    i_cur_insn_b = '0;
    err_count    = 0;
    tests_failed = 0;
    cur_test     = 0;
    seed = $urandom(9215);
    load_stim(ok);
    if (!ok || n_tests == 0) begin
      $display("stimulus could not be loaded, no test was run");
      $display("TB FAILED");
    end else begin
      stim_loaded = 1'b1;
      for (int t = 0; t < n_tests; t++) run_test(t);
      $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
               n_tests, n_tests - tests_failed, tests_failed, err_count);
      if (err_count == 0 && tests_failed == 0) $display("TB PASSED");
      else $display("TB FAILED");
    end
    $finish;
  end

  // budget of program length plus 20 cycles per test
  initial begin : watchdog
    int limit_ns;
    wait (stim_loaded);
    limit_ns = (n_words + 20 * n_tests) * CLK_PERIOD;
    #(limit_ns);
    $display("watchdog: run still going after %0d ns, stopping", limit_ns);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
source/lc4_pkg.sv
source/lc4_alu.sv
source/lc4_regfile_2w.sv
source/lc4_lane.sv
source/lc4_issue_ctrl.sv
source/lc4_superscalar.sv
test/tb_lc4_superscalar.sv

// ==== test/lc4_stim.txt ====
# test <name> <expected superscalar stall cycles> starts a program loaded at the reset pc
# p <insn hex> <wb rd> <wb data hex> <wb nzp bin> per word, r <rd> is CONST of a random value
test alu_ops 0
p 9207 1 0007 001
p 95fd 2 fffd 100
p 1642 3 0004 001
p 184a 4 ffeb 100
p 1a51 5 0000 010
p 1cbc 6 fff9 100
p 5e42 7 0005 001
p 5648 3 fff8 100
p 5852 4 ffff 100
p 5a99 5 fffa 100
p 5c63 6 0003 001
p 9000 0 0000 010
test pair_dep 4
p 9205 1 0005 001
p 1441 2 000a 001
p 1691 3 0005 001
p 18cb 4 0019 001
p 1a7b 5 0000 010
p 5d48 6 ffff 100
p 5f9c 7 ffe6 100
test cross_pair 0
p 92ff 1 00ff 001
p 9500 2 ff00 100
p 5652 3 ffff 100
p 1861 4 0100 001
p 5ac2 5 ff00 100
p 1d11 6 0001 001
p 1f46 7 ff01 100
p 50dc 0 feff 100
test same_dest 0
p 9203 1 0003 001
p 93ff 1 ffff 100
p 1441 2 fffe 100
p 1660 3 ffff 100
p 586f 4 000f 001
p 9a00 5 0000 010
test random_fill 2
r 4
r 5
r 6
r 7
p 9202 1 0002 001
p 1449 2 0004 001
p 1691 3 0002 001
